// ==== common/fp_format_pkg.sv ====
// IEEE 754 single precision layout, shared by the decomposers, the compare
// core and the result stage; import it where fields or constants are needed

package fp_format_pkg;

	// ========================================================================
	// format constants
	// ========================================================================

	localparam int FP_W     = 32;
	localparam int EXP_W    = 8;
	localparam int MANT_W   = 23;
	// mantissa msb, set for a quiet NaN
	localparam int QNAN_BIT = MANT_W - 1;

	// all ones exponent marks infinity or NaN
	localparam logic [EXP_W-1:0] EXP_MAX    = '1;
	// result of min/max when both inputs are NaN
	localparam logic [FP_W-1:0]  CANON_QNAN = 32'h7fc0_0000;

	// ========================================================================
	// operand views
	// ========================================================================

	// field split of one word, msb first
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exponent;
		logic [MANT_W-1:0] mantissa;
	} fp_fields_t;

	// raw bits for equality and output, fields for classification
	typedef union packed {
		logic [FP_W-1:0] raw;
		fp_fields_t      fields;
	} fp32_u;

	// decomposed operand with its class bits
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exponent;
		logic [MANT_W-1:0] mantissa;
		logic              zero;
		logic              inf;
		logic              nan;
		logic              qnan;
		logic              snan;
	} fp_info_t;

endpackage

// ==== common/fp_cmp_pkg.sv ====
// Operation codes and result types of the compare unit; used by the result
// stage, the top level and the testbench

package fp_cmp_pkg;

	// architectural compare / min / max operations
	typedef enum logic [2:0] {
		FEQ  = 3'd0,
		FLT  = 3'd1,
		FLE  = 3'd2,
		FMIN = 3'd3,
		FMAX = 3'd4
	} cmp_op_e;

	// relation flags, eq ends up in bit 0 and unordered in bit 4
	typedef struct packed {
		logic unordered;
		logic lt_mag;
		logic le;
		logic lt;
		logic eq;
	} cmp_flags_t;

	// registered output word
	typedef struct packed {
		// 0/1 for compares, an operand or qNaN for min/max
		logic [31:0] value;
		// invalid operation exception
		logic        invalid;
		// raw relation flags, carried for debug and fp status
		cmp_flags_t  flags;
	} cmp_result_t;

endpackage

// ==== fp_compare/fp_decomp.sv ====
// Splits one single precision operand into its fields and classifies it;
// purely combinational, one instance per compare operand

`timescale 1ns/1ps

module fp_decomp
	import fp_format_pkg::*;
(
	input  fp32_u    operand,
	output fp_info_t info
);

	// field view of the operand word
	fp_fields_t f;
	logic       exp_ones;
	logic       exp_zero;
	logic       man_zero;

	assign f = operand.fields;

	// exponent and mantissa extremes
	assign exp_ones = (f.exponent == EXP_MAX);
	assign exp_zero = (f.exponent == '0);
	assign man_zero = (f.mantissa == '0);

	// ========================================================================
	// field pass-through and classification
	// ========================================================================

	always_comb
	begin
		info.sign     = f.sign;
		info.exponent = f.exponent;
		info.mantissa = f.mantissa;

		// +0 or -0, denormals are not zero
		info.zero = exp_zero & man_zero;

		// max exponent with empty mantissa
		info.inf  = exp_ones & man_zero;
		// max exponent with any mantissa bit
		info.nan  = exp_ones & ~man_zero;

		// quiet/signalling split on mantissa msb
		info.qnan = info.nan & f.mantissa[QNAN_BIT];
		info.snan = info.nan & ~f.mantissa[QNAN_BIT];
	end

endmodule

// ==== fp_compare/fp_compare.sv ====
// IEEE 754 compare core: five relation flags from two decomposed operands.
// Combinational; the result stage registers the flags with the result.

`timescale 1ns/1ps

module fp_compare
	import fp_format_pkg::*;
	import fp_cmp_pkg::*;
(
	input  fp32_u      a,
	input  fp32_u      b,
	input  fp_info_t   info_a,
	input  fp_info_t   info_b,
	output cmp_flags_t flags
);

	// exponent and mantissa as one unsigned magnitude
	logic [EXP_W+MANT_W-1:0] mag_a;
	logic [EXP_W+MANT_W-1:0] mag_b;
	logic                    mag_lt;
	logic                    mag_gt;
	logic                    both_zero;
	logic                    unordered;
	logic                    eq;
	logic                    lt;

	assign mag_a = {info_a.exponent, info_a.mantissa};
	assign mag_b = {info_b.exponent, info_b.mantissa};

	// ========================================================================
	// magnitude compare
	// ========================================================================

	// biased exponent sits above the mantissa, so plain unsigned compare
	// orders denormals, normals and infinities correctly
	assign mag_lt = (mag_a < mag_b);
	assign mag_gt = (mag_a > mag_b);

	// +0 and -0 are one value
	assign both_zero = info_a.zero & info_b.zero;

	// ========================================================================
	// relations
	// ========================================================================

	// any NaN makes the pair unordered
	assign unordered = info_a.nan | info_b.nan;

	// equal bit patterns, or the signed zero pair
	assign eq = ~unordered & (both_zero | (a.raw == b.raw));

	always_comb
	begin
		if (unordered)
			lt = 1'b0;
		else if (info_a.sign != info_b.sign)
			// negative a is smaller, unless both are zero
			lt = info_a.sign & ~both_zero;
		else if (info_a.sign)
			// two negatives, larger magnitude is smaller
			lt = mag_gt;
		else
			lt = mag_lt;
	end

	// ========================================================================
	// flag vector
	// ========================================================================

	always_comb
	begin
		flags.eq        = eq;
		flags.lt        = lt;
		// le is low when unordered, since eq and lt are
		flags.le        = lt | eq;
		// raw magnitude result, not masked by NaN
		flags.lt_mag    = mag_lt;
		flags.unordered = unordered;
	end

endmodule

// ==== rtl/fp_cmp_result.sv ====
// Result stage: turns relation flags into FEQ/FLT/FLE/FMIN/FMAX results,
// raises invalid and registers everything one cycle after the input strobe

`timescale 1ns/1ps

module fp_cmp_result
	import fp_format_pkg::*;
	import fp_cmp_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  cmp_op_e     op,
	input  fp32_u       a,
	input  fp32_u       b,
	input  fp_info_t    info_a,
	input  fp_info_t    info_b,
	input  cmp_flags_t  flags,
	output logic        out_valid,
	output cmp_result_t result
);

	cmp_result_t      result_d;
	logic [FP_W-1:0]  min_val;
	logic [FP_W-1:0]  max_val;
	logic             both_zero;
	logic             any_nan;
	logic             any_snan;
	logic             pick_a_min;
	logic             pick_a_max;

	assign both_zero = info_a.zero & info_b.zero;
	assign any_nan   = info_a.nan | info_b.nan;
	assign any_snan  = info_a.snan | info_b.snan;

	// ========================================================================
	// min / max selection
	// ========================================================================

	// signed zero pair: min takes the negative one, max the positive one
	assign pick_a_min = flags.lt | (both_zero & info_a.sign);
	assign pick_a_max = ~flags.le | (both_zero & ~info_a.sign);

	always_comb
	begin
		if (info_a.nan & info_b.nan)
		begin
			min_val = CANON_QNAN;
			max_val = CANON_QNAN;
		end
		else if (info_a.nan)
		begin
			// single NaN yields the other operand
			min_val = b.raw;
			max_val = b.raw;
		end
		else if (info_b.nan)
		begin
			min_val = a.raw;
			max_val = a.raw;
		end
		else
		begin
			min_val = pick_a_min ? a.raw : b.raw;
			max_val = pick_a_max ? a.raw : b.raw;
		end
	end

	// ========================================================================
	// op decode
	// ========================================================================

	always_comb
	begin
		result_d       = '0;
		result_d.flags = flags;
		case (op)
			FEQ:
			begin
				result_d.value   = {31'd0, flags.eq};
				// quiet compare, only sNaN traps
				result_d.invalid = any_snan;
			end
			FLT:
			begin
				result_d.value   = {31'd0, flags.lt};
				// signalling compare, any NaN traps
				result_d.invalid = any_nan;
			end
			FLE:
			begin
				result_d.value   = {31'd0, flags.le};
				result_d.invalid = any_nan;
			end
			FMIN:
			begin
				result_d.value   = min_val;
				result_d.invalid = any_snan;
			end
			FMAX:
			begin
				result_d.value   = max_val;
				result_d.invalid = any_snan;
			end
			default:
			begin
				// unused codes give zero and no exception
				result_d.value   = '0;
				result_d.invalid = 1'b0;
			end
		endcase
	end

	// ========================================================================
	// output register
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			result    <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			// result holds between strobes
			if (in_valid)
				result <= result_d;
		end
	end

endmodule

// ==== rtl/fp_cmp_unit.sv ====
// Top level of the single precision compare unit: two decomposers, the
// compare core and the registered result stage; one op per cycle

`timescale 1ns/1ps

module fp_cmp_unit
	import fp_format_pkg::*;
	import fp_cmp_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  fp32_u       a,
	input  fp32_u       b,
	input  cmp_op_e     op,
	output logic        out_valid,
	output cmp_result_t result
);

	fp_info_t   info_a;
	fp_info_t   info_b;
	cmp_flags_t flags;

	// operand classification
	fp_decomp u_decomp_a (
		.operand (a),
		.info    (info_a)
	);

	fp_decomp u_decomp_b (
		.operand (b),
		.info    (info_b)
	);

	// relation flags, same cycle
	fp_compare u_compare (
		.a      (a),
		.b      (b),
		.info_a (info_a),
		.info_b (info_b),
		.flags  (flags)
	);

	// op decode and one cycle register
	fp_cmp_result u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.info_a    (info_a),
		.info_b    (info_b),
		.flags     (flags),
		.out_valid (out_valid),
		.result    (result)
	);

endmodule

// ==== testbench/tb_clock.sv ====
// Clock and reset source for the compare unit testbench
// 40 ns clock, rst_n held low for the first two rising edges

`timescale 1ns/1ps

module tb_clock
(
	output logic clk,
	output logic rst_n
);

	localparam time PERIOD = 40ns;

	initial
	begin
		clk   = 1'b0;
		rst_n = 1'b0;
		// release on a rising edge, like any other driven input
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== testbench/fp_cmp_unit_properties.sv ====
// Concurrent checks on the compare unit ports; bound into fp_cmp_unit
// from the testbench top

`timescale 1ns/1ps

module fp_cmp_unit_properties
	import fp_cmp_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        in_valid,
	input logic        out_valid,
	input cmp_result_t result
);

	// sync reset clears the output strobe on the following edge
	a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else
		begin
			$error("out_valid high after a reset cycle");
			tb_fp_cmp_unit.errors++;
		end

	// one cycle latency with no dropped or extra strobes
	a_strobe_follow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |=> out_valid)
		else
		begin
			$error("out_valid missing one cycle after in_valid");
			tb_fp_cmp_unit.errors++;
		end

	a_no_extra_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!in_valid |=> !out_valid)
		else
		begin
			$error("out_valid high without a preceding in_valid");
			tb_fp_cmp_unit.errors++;
		end

	// invalid only changes when a new result is presented
	a_invalid_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(result.invalid) |-> out_valid)
		else
		begin
			$error("invalid rose while out_valid was low");
			tb_fp_cmp_unit.errors++;
		end

endmodule

// ==== testbench/tb_fp_cmp_unit.sv ====
// Directed and random tests for the single precision compare unit
// a queue of expected results is checked whenever out_valid is high

`timescale 1ns/1ps

module tb_fp_cmp_unit;

	import fp_format_pkg::*;
	import fp_cmp_pkg::*;

	// ops issued by the directed tasks and the random stream
	localparam int N_DIRECTED  = 115;
	localparam int N_STREAM    = 200;
	localparam int CYCLE_LIMIT = 2 * (N_DIRECTED + N_STREAM);

	// handy operands
	localparam logic [31:0] P_ONE  = 32'h3f80_0000;
	localparam logic [31:0] P_TWO  = 32'h4000_0000;
	localparam logic [31:0] N_ONE  = 32'hbf80_0000;
	localparam logic [31:0] N_TWO  = 32'hc000_0000;
	localparam logic [31:0] P_ZERO = 32'h0000_0000;
	localparam logic [31:0] N_ZERO = 32'h8000_0000;
	localparam logic [31:0] P_INF  = 32'h7f80_0000;
	localparam logic [31:0] N_INF  = 32'hff80_0000;
	localparam logic [31:0] QNAN   = 32'h7fc0_0001;
	localparam logic [31:0] SNAN   = 32'h7f80_0001;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	fp32_u       a;
	fp32_u       b;
	cmp_op_e     op;
	logic        out_valid;
	cmp_result_t result;

	cmp_result_t exp_q [$];
	cmp_result_t expected;
	int          errors;
	int          cycles;
	int          seed;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fp_cmp_unit i_fp_cmp_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.op        (op),
		.out_valid (out_valid),
		.result    (result)
	);

	bind fp_cmp_unit fp_cmp_unit_properties u_props (.*);

	// ========================================================================
	// reference model
	// ========================================================================

	function automatic cmp_result_t ref_model(input cmp_op_e o, input logic [31:0] x,
		input logic [31:0] y);
		cmp_result_t r;
		logic        nan_x;
		logic        nan_y;
		logic        snan_any;
		logic        zeros;
		logic        unord;
		logic        eq;
		logic        lt;
		nan_x    = (x[30:23] == 8'hff) && (x[22:0] != 0);
		nan_y    = (y[30:23] == 8'hff) && (y[22:0] != 0);
		// quiet bit clear on a NaN means signalling
		snan_any = (nan_x && !x[22]) || (nan_y && !y[22]);
		zeros    = (x[30:0] == 0) && (y[30:0] == 0);
		unord    = nan_x || nan_y;
		eq       = !unord && (zeros || x == y);
		if (unord)
			lt = 1'b0;
		else if (x[31] != y[31])
			lt = x[31] && !zeros;
		else if (x[31])
			lt = x[30:0] > y[30:0];
		else
			lt = x[30:0] < y[30:0];
		r                 = '0;
		r.flags.eq        = eq;
		r.flags.lt        = lt;
		r.flags.le        = lt || eq;
		r.flags.lt_mag    = x[30:0] < y[30:0];
		r.flags.unordered = unord;
		case (o)
			FEQ:
			begin
				r.value   = eq;
				r.invalid = snan_any;
			end
			FLT:
			begin
				r.value   = lt;
				r.invalid = unord;
			end
			FLE:
			begin
				r.value   = lt || eq;
				r.invalid = unord;
			end
			FMIN, FMAX:
			begin
				r.invalid = snan_any;
				if (nan_x && nan_y)
					r.value = 32'h7fc0_0000;
				else if (nan_x)
					r.value = y;
				else if (nan_y)
					r.value = x;
				else if (zeros)
					// min keeps the negative zero, max the positive one
					r.value = ((o == FMIN) == x[31]) ? x : y;
				else
					r.value = ((o == FMIN) == lt) ? x : y;
			end
			default:
				r.value = '0;
		endcase
		return r;
	endfunction

	// ========================================================================
	// stimulus and checking
	// ========================================================================

	task automatic drive(input cmp_op_e o, input logic [31:0] x, input logic [31:0] y);
		@(posedge clk);
		in_valid <= 1'b1;
		op       <= o;
		a.raw    <= x;
		b.raw    <= y;
		exp_q.push_back(ref_model(o, x, y));
	endtask

	// one op, then wait until its result has been checked
	task automatic apply_op(input cmp_op_e o, input logic [31:0] x, input logic [31:0] y);
		drive(o, x, y);
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic apply_all(input logic [31:0] x, input logic [31:0] y);
		for (int k = 0; k < 5; k++)
			apply_op(cmp_op_e'(k), x, y);
	endtask

	// random word biased toward zeros, denormals and inf/NaN exponents
	function automatic logic [31:0] random_operand();
		logic [31:0] w;
		logic [31:0] k;
		w = $random(seed);
		k = $random(seed);
		case (k[2:0])
			3'd0: w[30:23] = 8'hff;
			3'd1: w[30:0] = '0;
			3'd2: w[30:23] = 8'h00;
			default: w = w;
		endcase
		return w;
	endfunction

	// expected results are popped and compared at the falling edge
	always @(negedge clk)
	begin
		if (rst_n && out_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				errors++;
				$display("out_valid high at %0t with no operation pending", $time);
			end
			if (exp_q.size() != 0)
			begin
				expected = exp_q.pop_front();
				assert (result === expected)
				else
				begin
					errors++;
					$display("Mismatch at %0t: result %h, expected %h",
						$time, result, expected);
				end
			end
		end
	end

	// ========================================================================
	// tests
	// ========================================================================

	task automatic test_reset();
		@(negedge clk);
		assert (out_valid === 1'b0 && result === '0)
		else
		begin
			errors++;
			$display("Mismatch at %0t: outputs not cleared after reset", $time);
		end
	endtask

	task automatic test_ordered();
		apply_all(P_ONE, P_TWO);
		apply_all(P_TWO, P_ONE);
		apply_all(N_ONE, P_TWO);
		apply_all(N_TWO, N_ONE);
		apply_all(N_ONE, N_TWO);
		apply_all(P_ONE, P_ONE);
		// denormals, including a negative one
		apply_all(32'h0000_0001, 32'h0000_0002);
		apply_all(32'h8000_0001, 32'h0000_0001);
		apply_all(P_INF, 32'h7f7f_ffff);
		apply_all(N_INF, P_INF);
	endtask

	task automatic test_signed_zero();
		apply_all(P_ZERO, N_ZERO);
		apply_all(N_ZERO, P_ZERO);
		apply_all(N_ZERO, N_ZERO);
		apply_all(P_ZERO, P_ZERO);
	endtask

	task automatic test_nan_compare();
		apply_all(QNAN, P_ONE);
		apply_all(P_ONE, QNAN);
		apply_all(SNAN, P_ONE);
		apply_all(N_ONE, SNAN);
	endtask

	task automatic test_minmax_nan();
		apply_all(QNAN, 32'hc040_0000);
		apply_all(32'hc040_0000, SNAN);
		apply_all(QNAN, SNAN);
		apply_all(SNAN, SNAN);
		apply_all(QNAN, QNAN);
	endtask

	// back to back ops with a new one every cycle
	task automatic test_stream();
		logic [31:0] k;
		for (int i = 0; i < N_STREAM; i++)
		begin
			k = $random(seed);
			drive(cmp_op_e'(k % 5), random_operand(), random_operand());
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	// ========================================================================
	// run control
	// ========================================================================

	task automatic finish_run(input bit timed_out);
		$display("errors: %0d, results still pending: %0d", errors, exp_q.size());
		if (errors == 0 && !timed_out)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT)
		begin
			$display("timeout: run not finished after %0d cycles", CYCLE_LIMIT);
			finish_run(1'b1);
		end
	end

	initial
	begin
		seed     = 3778;
		errors   = 0;
		cycles   = 0;
		in_valid = 1'b0;
		op       = FEQ;
		a        = '0;
		b        = '0;
		wait (rst_n === 1'b1);
		test_reset();
		test_ordered();
		test_signed_zero();
		test_nan_compare();
		test_minmax_nan();
		test_stream();
		finish_run(1'b0);
	end

endmodule

// ==== sim.f ====
common/fp_format_pkg.sv
common/fp_cmp_pkg.sv
fp_compare/fp_decomp.sv
fp_compare/fp_compare.sv
rtl/fp_cmp_result.sv
rtl/fp_cmp_unit.sv
testbench/tb_clock.sv
testbench/fp_cmp_unit_properties.sv
testbench/tb_fp_cmp_unit.sv

// ==== Bender.yml ====
package:
  name: fp_cmp_unit

sources:
  - common/fp_format_pkg.sv
  - common/fp_cmp_pkg.sv
  - fp_compare/fp_decomp.sv
  - fp_compare/fp_compare.sv
  - rtl/fp_cmp_result.sv
  - rtl/fp_cmp_unit.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/fp_cmp_unit_properties.sv
      - testbench/tb_fp_cmp_unit.sv
